//--- include/wasm_consts.svh
`ifndef WASM_CONSTS_SVH
`define WASM_CONSTS_SVH

// Code memory and operand stack sizes
`define CODE_ADDR_W   6
`define CODE_DEPTH    64
`define STACK_DEPTH   8
`define WINDOW_BYTES  10

// Opcodes, standard WebAssembly encodings
`define OP_UNREACHABLE          8'h00
`define OP_NOP                  8'h01
`define OP_END                  8'h0b
`define OP_DROP                 8'h1a
`define OP_SELECT               8'h1b
`define OP_I32_CONST            8'h41
`define OP_I64_CONST            8'h42
`define OP_F32_CONST            8'h43
`define OP_F64_CONST            8'h44
`define OP_I32_EQZ              8'h45
`define OP_I64_EQZ              8'h50
`define OP_I32_REINTERPRET_F32  8'hbc
`define OP_I64_REINTERPRET_F64  8'hbd
`define OP_F32_REINTERPRET_I32  8'hbe
`define OP_F64_REINTERPRET_I64  8'hbf

// Value type tags
`define TYPE_I32  2'd0
`define TYPE_I64  2'd1
`define TYPE_F32  2'd2
`define TYPE_F64  2'd3

// Operand stack operations
`define SOP_NONE     2'd0
`define SOP_PUSH     2'd1
`define SOP_POP      2'd2
`define SOP_REPLACE  2'd3

// Operand stack status
`define SST_EMPTY  2'd0
`define SST_OK     2'd1
`define SST_FULL   2'd2
`define SST_ERROR  2'd3

// Trap codes
`define TRAP_NONE         3'd0
`define TRAP_STACK        3'd1
`define TRAP_CODE_END     3'd2
`define TRAP_UNREACHABLE  3'd3
`define TRAP_BAD_OPCODE   3'd4
`define TRAP_SELECT_TYPE  3'd6

`endif

//--- hw/wasm_pkg.sv
`include "wasm_consts.svh"

package wasm_pkg;

  typedef logic [63:0] word_t;
  typedef logic [1:0]  val_type_t;

  // Tag in [65:64], payload in [63:0]
  typedef logic [65:0] stack_entry_t;

  typedef logic [`CODE_ADDR_W-1:0]    code_addr_t;
  typedef logic [7:0]                 code_byte_t;
  // Byte 0 in the low bits, from the lowest address
  typedef logic [8*`WINDOW_BYTES-1:0] code_window_t;

  typedef logic [1:0] stack_op_t;
  typedef logic [1:0] stack_status_t;
  typedef logic [2:0] trap_t;
  typedef logic [3:0] leb_len_t;

  typedef enum logic [2:0] {
    FETCH,
    DECODE,
    EXEC2,
    MEMORY,
    MEMORY2
  } exec_state_t;

endpackage

//--- hw/code_mem.sv
`timescale 1ns/1ps
`include "wasm_consts.svh"

module code_mem (
  input  logic                   clk,
  input  logic                   prog_we,
  input  wasm_pkg::code_addr_t   prog_addr,
  input  wasm_pkg::code_byte_t   prog_data,
  input  wasm_pkg::code_addr_t   rd_addr,
  output wasm_pkg::code_window_t rd_window,
  output logic                   rd_error
);
  import wasm_pkg::*;

  code_byte_t              mem [`CODE_DEPTH];
  code_window_t            window_next;
  logic [`CODE_ADDR_W:0]   byte_addr;
  logic [`CODE_ADDR_W:0]   end_addr;

  // One extra bit so the window end can pass the last byte
  assign end_addr = {1'b0, rd_addr} + (`CODE_ADDR_W+1)'(`WINDOW_BYTES);

  always_ff @(posedge clk) begin
    if (prog_we) begin
      mem[prog_addr] <= prog_data;
    end
  end

  // Gather the window, bytes past the end read as zero
  always_comb begin
    window_next = '0;
    byte_addr   = '0;
    for (int i = 0; i < `WINDOW_BYTES; i++) begin
      byte_addr = {1'b0, rd_addr} + (`CODE_ADDR_W+1)'(i);
      if (byte_addr < (`CODE_ADDR_W+1)'(`CODE_DEPTH)) begin
        window_next[8*i +: 8] = mem[byte_addr[`CODE_ADDR_W-1:0]];
      end
    end
  end

  always_ff @(posedge clk) begin
    rd_window <= window_next;
    rd_error  <= end_addr > (`CODE_ADDR_W+1)'(`CODE_DEPTH);
  end

endmodule

//--- hw/operand_stack.sv
`timescale 1ns/1ps
`include "wasm_consts.svh"

module operand_stack (
  input  logic                    clk,
  input  logic                    reset,
  input  wasm_pkg::stack_op_t     op,
  input  wasm_pkg::stack_entry_t  data,
  output wasm_pkg::stack_entry_t  tos,
  output wasm_pkg::stack_status_t status
);
  import wasm_pkg::*;

  localparam int CNT_W = $clog2(`STACK_DEPTH + 1);
  localparam int PTR_W = $clog2(`STACK_DEPTH);

  stack_entry_t     mem [`STACK_DEPTH];
  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] top_idx;
  logic [CNT_W-1:0] below_idx;
  logic             error;
  logic             is_empty;
  logic             is_full;

  assign is_empty  = count == '0;
  assign is_full   = count == CNT_W'(`STACK_DEPTH);
  assign top_idx   = count - 1'b1;
  assign below_idx = count - 2'd2;

  // Count and sticky error
  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
      error <= 1'b0;
    end else if (!error) begin
      case (op)
        `SOP_PUSH: begin
          if (is_full) error <= 1'b1;
          else count <= count + 1'b1;
        end
        `SOP_POP: begin
          if (is_empty) error <= 1'b1;
          else count <= count - 1'b1;
        end
        `SOP_REPLACE: begin
          if (is_empty) error <= 1'b1;
        end
        default: ;
      endcase
    end
  end

  // Entries and the registered top copy
  always_ff @(posedge clk) begin
    case (op)
      `SOP_PUSH: begin
        if (!is_full) begin
          mem[count[PTR_W-1:0]] <= data;
          tos                   <= data;
        end
      end
      // Entry below becomes the top, meaningless once empty
      `SOP_POP: tos <= mem[below_idx[PTR_W-1:0]];
      `SOP_REPLACE: begin
        if (!is_empty) begin
          mem[top_idx[PTR_W-1:0]] <= data;
          tos                     <= data;
        end
      end
      default: ;
    endcase
  end

  always_comb begin
    if (error) status = `SST_ERROR;
    else if (is_empty) status = `SST_EMPTY;
    else if (is_full) status = `SST_FULL;
    else status = `SST_OK;
  end

endmodule

//--- hw/leb128_decoder.sv
`timescale 1ns/1ps
`include "wasm_consts.svh"

module leb128_decoder (
  input  wasm_pkg::code_window_t bytes,
  output wasm_pkg::word_t        value,
  output wasm_pkg::leb_len_t     len
);
  import wasm_pkg::*;

  logic [7*`WINDOW_BYTES-1:0] groups;
  leb_len_t                   last;
  logic                       found;
  logic                       sign;

  always_comb begin
    last  = leb_len_t'(`WINDOW_BYTES - 1);
    found = 1'b0;
    sign  = 1'b0;
    // First byte with the continuation bit clear
    for (int i = 0; i < `WINDOW_BYTES; i++) begin
      if (!found && !bytes[8*i+7]) begin
        last  = leb_len_t'(i);
        found = 1'b1;
      end
    end
    for (int i = 0; i < `WINDOW_BYTES; i++) begin
      if (leb_len_t'(i) == last) sign = bytes[8*i+6];
    end
    // Little-endian 7-bit groups, sign fill above the last one
    for (int i = 0; i < `WINDOW_BYTES; i++) begin
      if (leb_len_t'(i) <= last) groups[7*i +: 7] = bytes[8*i +: 7];
      else groups[7*i +: 7] = {7{sign}};
    end
  end

  assign value = groups[63:0];
  assign len   = last + 1'b1;

endmodule

//--- hw/exec_unit.sv
`timescale 1ns/1ps
`include "wasm_consts.svh"

module exec_unit (
  input  logic                    clk,
  input  logic                    reset,
  output wasm_pkg::code_addr_t    rd_addr,
  input  wasm_pkg::code_window_t  rd_window,
  input  logic                    rd_error,
  output wasm_pkg::stack_op_t     stack_op,
  output wasm_pkg::stack_entry_t  stack_data,
  input  wasm_pkg::stack_entry_t  tos,
  input  wasm_pkg::stack_status_t stack_status,
  output wasm_pkg::word_t         result,
  output wasm_pkg::val_type_t     result_type,
  output logic                    result_empty,
  output logic                    result_valid,
  output wasm_pkg::trap_t         trap
);
  import wasm_pkg::*;

  exec_state_t  state;
  code_addr_t   pc;
  code_byte_t   opcode;
  code_byte_t   opcode_q;
  logic         cond_nz_q;
  stack_entry_t val2_q;
  code_window_t imm_q;
  word_t        leb_value;
  leb_len_t     leb_len;
  logic         decode_ok;
  logic         stack_live;
  logic         select_ok;

  assign rd_addr   = pc;
  assign opcode    = rd_window[7:0];
  assign decode_ok = (stack_status != `SST_ERROR) && !rd_error;
  // val1 must still be on the stack after both select pops
  assign stack_live = (stack_status != `SST_ERROR) && (stack_status != `SST_EMPTY);
  assign select_ok  = stack_live && (tos[65:64] == val2_q[65:64]);

  leb128_decoder leb_i (
    .bytes (imm_q),
    .value (leb_value),
    .len   (leb_len)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      state        <= FETCH;
      pc           <= '0;
      trap         <= `TRAP_NONE;
      result_valid <= 1'b0;
    end else begin
      result_valid <= 1'b0;
      if (trap == `TRAP_NONE) begin
        case (state)
          FETCH: begin
            pc    <= pc + 1'b1;
            state <= DECODE;
          end
          DECODE: begin
            opcode_q  <= opcode;
            cond_nz_q <= |tos[63:0];
            state     <= FETCH;
            if (stack_status == `SST_ERROR) trap <= `TRAP_STACK;
            else if (rd_error) trap <= `TRAP_CODE_END;
            else begin
              case (opcode)
                `OP_UNREACHABLE: trap <= `TRAP_UNREACHABLE;
                `OP_END: begin
                  result       <= tos[63:0];
                  result_type  <= tos[65:64];
                  result_empty <= stack_status == `SST_EMPTY;
                  result_valid <= 1'b1;
                end
                `OP_SELECT: state <= EXEC2;
                `OP_I32_CONST, `OP_I64_CONST,
                `OP_F32_CONST, `OP_F64_CONST: state <= MEMORY;
                `OP_NOP, `OP_DROP, `OP_I32_EQZ, `OP_I64_EQZ,
                `OP_I32_REINTERPRET_F32, `OP_I64_REINTERPRET_F64,
                `OP_F32_REINTERPRET_I32, `OP_F64_REINTERPRET_I64: ;
                default: trap <= `TRAP_BAD_OPCODE;
              endcase
            end
          end
          // Condition popped, val2 now on top
          EXEC2: begin
            val2_q <= tos;
            state  <= MEMORY2;
          end
          // Immediate window arrived
          MEMORY: begin
            if (rd_error) trap <= `TRAP_CODE_END;
            else begin
              if (opcode_q == `OP_I32_CONST) imm_q <= code_window_t'(rd_window[39:0]);
              else imm_q <= rd_window;
              state <= MEMORY2;
            end
          end
          MEMORY2: begin
            state <= FETCH;
            case (opcode_q)
              `OP_SELECT: begin
                if (!stack_live) trap <= `TRAP_STACK;
                else if (!select_ok) trap <= `TRAP_SELECT_TYPE;
              end
              `OP_F32_CONST: pc <= pc + code_addr_t'(4);
              `OP_F64_CONST: pc <= pc + code_addr_t'(8);
              default: pc <= pc + code_addr_t'(leb_len);
            endcase
          end
          default: state <= FETCH;
        endcase
      end
    end
  end

  // Stack requests, applied at the end of the same cycle
  always_comb begin
    stack_op   = `SOP_NONE;
    stack_data = '0;
    if (trap == `TRAP_NONE) begin
      case (state)
        DECODE: begin
          if (decode_ok) begin
            case (opcode)
              `OP_DROP, `OP_SELECT: stack_op = `SOP_POP;
              `OP_I32_EQZ: begin
                stack_op   = `SOP_REPLACE;
                stack_data = {`TYPE_I32, 63'd0, ~|tos[31:0]};
              end
              `OP_I64_EQZ: begin
                stack_op   = `SOP_REPLACE;
                stack_data = {`TYPE_I64, 63'd0, ~|tos[63:0]};
              end
              `OP_I32_REINTERPRET_F32: begin
                stack_op   = `SOP_REPLACE;
                stack_data = {`TYPE_I32, 32'd0, tos[31:0]};
              end
              `OP_I64_REINTERPRET_F64: begin
                stack_op   = `SOP_REPLACE;
                stack_data = {`TYPE_I64, tos[63:0]};
              end
              `OP_F32_REINTERPRET_I32: begin
                stack_op   = `SOP_REPLACE;
                stack_data = {`TYPE_F32, 32'd0, tos[31:0]};
              end
              `OP_F64_REINTERPRET_I64: begin
                stack_op   = `SOP_REPLACE;
                stack_data = {`TYPE_F64, tos[63:0]};
              end
              default: ;
            endcase
          end
        end
        EXEC2: stack_op = `SOP_POP;
        MEMORY2: begin
          case (opcode_q)
            // Zero condition keeps val2 in place of val1
            `OP_SELECT: begin
              if (select_ok && !cond_nz_q) begin
                stack_op   = `SOP_REPLACE;
                stack_data = val2_q;
              end
            end
            `OP_I32_CONST: begin
              stack_op   = `SOP_PUSH;
              stack_data = {`TYPE_I32, 32'd0, leb_value[31:0]};
            end
            `OP_I64_CONST: begin
              stack_op   = `SOP_PUSH;
              stack_data = {`TYPE_I64, leb_value};
            end
            `OP_F32_CONST: begin
              stack_op   = `SOP_PUSH;
              stack_data = {`TYPE_F32, 32'd0, imm_q[31:0]};
            end
            `OP_F64_CONST: begin
              stack_op   = `SOP_PUSH;
              stack_data = {`TYPE_F64, imm_q[63:0]};
            end
            default: ;
          endcase
        end
        default: ;
      endcase
    end
  end

endmodule

//--- hw/wasm_core.sv
`timescale 1ns/1ps

module wasm_core (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 prog_we,
  input  wasm_pkg::code_addr_t prog_addr,
  input  wasm_pkg::code_byte_t prog_data,
  output wasm_pkg::word_t      result,
  output wasm_pkg::val_type_t  result_type,
  output logic                 result_empty,
  output logic                 result_valid,
  output wasm_pkg::trap_t      trap
);
  import wasm_pkg::*;

  code_addr_t    rd_addr;
  code_window_t  rd_window;
  logic          rd_error;
  stack_op_t     stack_op;
  stack_entry_t  stack_data;
  stack_entry_t  tos;
  stack_status_t stack_status;

  code_mem code_mem_i (
    .clk       (clk),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .rd_addr   (rd_addr),
    .rd_window (rd_window),
    .rd_error  (rd_error)
  );

  operand_stack operand_stack_i (
    .clk    (clk),
    .reset  (reset),
    .op     (stack_op),
    .data   (stack_data),
    .tos    (tos),
    .status (stack_status)
  );

  exec_unit exec_unit_i (
    .clk          (clk),
    .reset        (reset),
    .rd_addr      (rd_addr),
    .rd_window    (rd_window),
    .rd_error     (rd_error),
    .stack_op     (stack_op),
    .stack_data   (stack_data),
    .tos          (tos),
    .stack_status (stack_status),
    .result       (result),
    .result_type  (result_type),
    .result_empty (result_empty),
    .result_valid (result_valid),
    .trap         (trap)
  );

endmodule

//--- verif/wasm_core_tb.sv
`timescale 1ns/1ps
`include "wasm_consts.svh"

module wasm_core_tb;
  import wasm_pkg::*;

  logic          clk = 1'b0;
  logic          reset;
  logic          prog_we;
  code_addr_t    prog_addr;
  code_byte_t    prog_data;
  word_t         result;
  val_type_t     result_type;
  logic          result_empty;
  logic          result_valid;
  trap_t         trap;

  int            errors = 0;
  logic [31:0]   rng_state = 32'hf30ff920;
  code_byte_t    program_q[$];

  wasm_core dut_i (
    .clk          (clk),
    .reset        (reset),
    .prog_we      (prog_we),
    .prog_addr    (prog_addr),
    .prog_data    (prog_data),
    .result       (result),
    .result_type  (result_type),
    .result_empty (result_empty),
    .result_valid (result_valid),
    .trap         (trap)
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] xorshift32();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (exp !== act) begin
      $display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_type(input string name, input val_type_t exp, input val_type_t act);
    if (exp !== act) begin
      $display("Mismatch at %0t: %s expected %0d, got %0d", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_trap(input string name, input trap_t exp, input trap_t act);
    if (exp !== act) begin
      $display("Mismatch at %0t: %s expected %0d, got %0d", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("Mismatch at %0t: %s expected %b, got %b", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic emit(input code_byte_t b);
    program_q.push_back(b);
  endtask

  // Signed LEB128 in its shortest form
  task automatic emit_sleb(input word_t value);
    logic signed [63:0] rest;
    code_byte_t         b;
    logic               done;
    rest = value;
    done = 1'b0;
    while (!done) begin
      b    = {1'b0, rest[6:0]};
      rest = rest >>> 7;
      if ((rest == 64'sd0 && !b[6]) || (rest == -64'sd1 && b[6])) done = 1'b1;
      else b[7] = 1'b1;
      program_q.push_back(b);
    end
  endtask

  task automatic emit_le(input word_t value, input int nbytes);
    for (int i = 0; i < nbytes; i++) begin
      program_q.push_back(value[8*i +: 8]);
    end
  endtask

  task automatic emit_i32_const(input logic [31:0] value);
    emit(`OP_I32_CONST);
    emit_sleb({{32{value[31]}}, value});
  endtask

  task automatic emit_i64_const(input word_t value);
    emit(`OP_I64_CONST);
    emit_sleb(value);
  endtask

  task automatic emit_f32_const(input logic [31:0] bits);
    emit(`OP_F32_CONST);
    emit_le({32'd0, bits}, 4);
  endtask

  task automatic emit_f64_const(input word_t bits);
    emit(`OP_F64_CONST);
    emit_le(bits, 8);
  endtask

  // Load the program under reset and fill the rest with unreachable
  task automatic load_and_start();
    if (program_q.size() > `CODE_DEPTH) begin
      $display("Program of %0d bytes does not fit in code memory", program_q.size());
      errors++;
    end
    @(negedge clk);
    reset = 1'b1;
    for (int a = 0; a < `CODE_DEPTH; a++) begin
      prog_we   = 1'b1;
      prog_addr = code_addr_t'(a);
      prog_data = (a < program_q.size()) ? program_q[a] : 8'h00;
      @(negedge clk);
    end
    prog_we = 1'b0;
    repeat (10) @(negedge clk);
    reset = 1'b0;
  endtask

  task automatic wait_for_event(output logic seen);
    seen = 1'b0;
    for (int i = 0; i < 200 && !seen; i++) begin
      @(negedge clk);
      if (result_valid || trap != `TRAP_NONE) seen = 1'b1;
    end
    if (!seen) begin
      $display("Timeout at %0t: no result and no trap within 200 cycles", $time);
      errors++;
    end
  endtask

  task automatic expect_result(input word_t value, input val_type_t vtype, input logic empty);
    logic seen;
    wait_for_event(seen);
    if (seen) begin
      if (trap != `TRAP_NONE) begin
        $display("Unexpected trap %0d at %0t while waiting for a result", trap, $time);
        errors++;
      end else begin
        check_word("result", value, result);
        check_type("result_type", vtype, result_type);
        check_bit("result_empty", empty, result_empty);
      end
    end
  endtask

  task automatic expect_empty();
    logic seen;
    wait_for_event(seen);
    if (seen) begin
      if (trap != `TRAP_NONE) begin
        $display("Unexpected trap %0d at %0t while waiting for a result", trap, $time);
        errors++;
      end else begin
        check_bit("result_empty", 1'b1, result_empty);
      end
    end
  endtask

  // Trap must hold and no result may follow it
  task automatic expect_trap(input trap_t code);
    logic seen;
    wait_for_event(seen);
    if (seen) begin
      if (result_valid) begin
        $display("Expected trap %0d but a result arrived at %0t", code, $time);
        errors++;
      end else begin
        check_trap("trap", code, trap);
        for (int i = 0; i < 20; i++) begin
          @(negedge clk);
          if (result_valid) begin
            $display("result_valid went high after a trap at %0t", $time);
            errors++;
          end
        end
        check_trap("trap", code, trap);
      end
    end
  endtask

  task automatic const_program(input logic [31:0] v32, input word_t v64,
                               input logic [31:0] f32_bits, input word_t f64_bits);
    program_q.delete();
    emit_i32_const(v32);
    emit(`OP_END);
    emit_i64_const(v64);
    emit(`OP_END);
    emit_f32_const(f32_bits);
    emit(`OP_END);
    emit_f64_const(f64_bits);
    emit(`OP_END);
    load_and_start();
    expect_result({32'd0, v32}, `TYPE_I32, 1'b0);
    expect_result(v64, `TYPE_I64, 1'b0);
    expect_result({32'd0, f32_bits}, `TYPE_F32, 1'b0);
    expect_result(f64_bits, `TYPE_F64, 1'b0);
  endtask

  task automatic test_constants();
    for (int i = 0; i < 4; i++) begin
      const_program(xorshift32(), {xorshift32(), xorshift32()},
                    xorshift32(), {xorshift32(), xorshift32()});
    end
    // Five and ten byte encodings of both signs
    const_program(32'h8000_0000, 64'h8000_0000_0000_0000, 32'hbf80_0000, 64'hfff0_0000_0000_0000);
    const_program(32'h7fff_ffff, 64'h4000_0000_0000_0000, 32'h7f80_0000, 64'h7ff8_0000_0000_0001);
    const_program(32'hffff_ffff, 64'hffff_ffff_ffff_ffff, 32'h0000_0000, 64'h0);
  endtask

  task automatic test_eqz();
    logic [31:0] nz32;
    nz32 = xorshift32() | 32'h1;
    program_q.delete();
    emit_i32_const(32'h0);
    emit(`OP_I32_EQZ);
    emit(`OP_END);
    emit(`OP_NOP);
    emit_i32_const(nz32);
    emit(`OP_NOP);
    emit(`OP_I32_EQZ);
    emit(`OP_END);
    emit_i64_const(64'h0);
    emit(`OP_I64_EQZ);
    emit(`OP_END);
    // Only the upper half set
    emit_i64_const(64'h1_0000_0000);
    emit(`OP_I64_EQZ);
    emit(`OP_END);
    load_and_start();
    expect_result(64'd1, `TYPE_I32, 1'b0);
    expect_result(64'd0, `TYPE_I32, 1'b0);
    expect_result(64'd1, `TYPE_I64, 1'b0);
    expect_result(64'd0, `TYPE_I64, 1'b0);
  endtask

  task automatic test_reinterpret();
    logic [31:0] f32_bits;
    logic [31:0] i32_val;
    word_t       i64_val;
    word_t       f64_bits;
    f32_bits = xorshift32();
    i32_val  = xorshift32();
    i64_val  = {xorshift32(), xorshift32()};
    f64_bits = {xorshift32(), xorshift32()};
    program_q.delete();
    emit_f32_const(f32_bits);
    emit(`OP_I32_REINTERPRET_F32);
    emit(`OP_END);
    emit_i64_const(i64_val);
    emit(`OP_F64_REINTERPRET_I64);
    emit(`OP_END);
    emit_f64_const(f64_bits);
    emit(`OP_I64_REINTERPRET_F64);
    emit(`OP_END);
    emit_i32_const(i32_val);
    emit(`OP_F32_REINTERPRET_I32);
    emit(`OP_END);
    load_and_start();
    expect_result({32'd0, f32_bits}, `TYPE_I32, 1'b0);
    expect_result(i64_val, `TYPE_F64, 1'b0);
    expect_result(f64_bits, `TYPE_I64, 1'b0);
    expect_result({32'd0, i32_val}, `TYPE_F32, 1'b0);

    // Wide payloads into the 32-bit targets lose their upper half
    program_q.delete();
    emit_f64_const(f64_bits);
    emit(`OP_I32_REINTERPRET_F32);
    emit(`OP_END);
    emit_i64_const(i64_val);
    emit(`OP_F32_REINTERPRET_I32);
    emit(`OP_END);
    load_and_start();
    expect_result({32'd0, f64_bits[31:0]}, `TYPE_I32, 1'b0);
    expect_result({32'd0, i64_val[31:0]}, `TYPE_F32, 1'b0);
  endtask

  task automatic test_select_drop();
    word_t       a64;
    word_t       b64;
    logic [31:0] a32;
    logic [31:0] b32;
    a64 = {xorshift32(), xorshift32()};
    b64 = {xorshift32(), xorshift32()};
    a32 = xorshift32();
    b32 = xorshift32();
    program_q.delete();
    emit_i64_const(a64);
    emit_i64_const(b64);
    emit_i32_const(32'd7);
    emit(`OP_SELECT);
    emit(`OP_END);
    emit(`OP_DROP);
    emit_f32_const(a32);
    emit_f32_const(b32);
    emit_i32_const(32'd0);
    emit(`OP_SELECT);
    emit(`OP_END);
    emit(`OP_DROP);
    emit(`OP_END);
    load_and_start();
    expect_result(a64, `TYPE_I64, 1'b0);
    expect_result({32'd0, b32}, `TYPE_F32, 1'b0);
    expect_empty();
  endtask

  task automatic test_traps();
    program_q.delete();
    emit(`OP_UNREACHABLE);
    load_and_start();
    expect_trap(`TRAP_UNREACHABLE);

    program_q.delete();
    emit_i32_const(32'd1);
    emit(8'h6a);
    load_and_start();
    expect_trap(`TRAP_BAD_OPCODE);

    program_q.delete();
    emit_i32_const(32'd1);
    emit_i64_const(64'd2);
    emit_i32_const(32'd1);
    emit(`OP_SELECT);
    emit(`OP_END);
    load_and_start();
    expect_trap(`TRAP_SELECT_TYPE);

    // One push more than the stack holds
    program_q.delete();
    for (int i = 0; i < `STACK_DEPTH + 1; i++) begin
      emit_i32_const(xorshift32() & 32'h3f);
    end
    emit(`OP_END);
    load_and_start();
    expect_trap(`TRAP_STACK);

    program_q.delete();
    emit(`OP_DROP);
    emit(`OP_END);
    load_and_start();
    expect_trap(`TRAP_STACK);

    // Six f64 constants end at byte 54 and the nop moves PC past the window limit
    program_q.delete();
    for (int i = 0; i < 6; i++) begin
      emit_f64_const({xorshift32(), xorshift32()});
    end
    emit(`OP_NOP);
    load_and_start();
    expect_trap(`TRAP_CODE_END);
  endtask

  initial begin
    reset     = 1'b1;
    prog_we   = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    test_constants();
    test_eqz();
    test_reinterpret();
    test_select_drop();
    test_traps();
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- filelist.f
+incdir+include
hw/wasm_pkg.sv
hw/code_mem.sv
hw/operand_stack.sv
hw/leb128_decoder.sv
hw/exec_unit.sv
hw/wasm_core.sv
verif/wasm_core_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       := wasm_core_tb
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := All tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
